// ==== run_sim.sh ====
#!/bin/sh
# build and run the register block testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f --top-module tb_delqa_regs -o sim_tb_delqa_regs \
	&& ./obj_dir/sim_tb_delqa_regs | tee /dev/stderr | grep -q "PASS: all tests" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== src/bus_arbiter.sv ====
// Host register arbiter
// one bus at a time owns the host registers, host bus wins a tie;
// delayed acknowledges for the host registers and the ethernet bank
`timescale 1ns/1ps

module bus_arbiter (
	input  logic                lwb_clk_i,
	input  logic                comb_res,
	input  delqa_pkg::bus_req_t lwb_req_i,
	input  delqa_pkg::bus_req_t ewb_req_i,
	input  logic                eth_stb_i,
	output logic                lwb_ack_o,
	output logic                ewb_ack_o,
	output logic                eth_ack_o,	// ethernet bank ack alone
	output logic                lwb_wr_o,
	output logic                lwb_rd_o,
	output logic                ewb_wr_o,
	output logic                ewb_rd_o
);
	import delqa_pkg::*;

	logic       gnt_l, gnt_e;	// grants
	logic [1:0] lack, eack;	// ack delay per bus
	logic [2:0] etack;	// ethernet bank ack delay
	logic       lrg_ack;
	logic       lcyc, ecyc;

	assign lcyc = lwb_req_i.cyc & lwb_req_i.stb;
	assign ecyc = ewb_req_i.cyc & ewb_req_i.stb;

	// *******************************************************************
	// grants and ack shift registers
	always_ff @(posedge lwb_clk_i or posedge comb_res) begin
		if (comb_res) begin
			gnt_l <= 1'b0;
			gnt_e <= 1'b0;
			lack  <= '0;
			eack  <= '0;
			etack <= '0;
		end else begin
			if (!gnt_l && !gnt_e) begin
				gnt_e <= ecyc;	// host bus first
				gnt_l <= lcyc & ~ecyc;
			end else begin
				if (gnt_l && !lcyc)
					gnt_l <= 1'b0;	// released on end of cycle
				if (gnt_e && !ecyc)
					gnt_e <= 1'b0;
			end
			lack  <= gnt_l ? {lwb_req_i.cyc & lack[0], lcyc} : 2'b00;
			eack  <= gnt_e ? {ewb_req_i.cyc & eack[0], ecyc} : 2'b00;
			etack <= {lwb_req_i.cyc & etack[1], lwb_req_i.cyc & etack[0],
				lwb_req_i.cyc & eth_stb_i};
		end
	end

	assign lrg_ack   = lcyc & lack[1];
	assign ewb_ack_o = ecyc & eack[1];
	assign eth_ack_o = lwb_req_i.cyc & eth_stb_i & etack[2];
	assign lwb_ack_o = lrg_ack | eth_ack_o;

	// access strobes, granted and not yet acked
	assign lwb_wr_o = lcyc & gnt_l & ~lrg_ack & lwb_req_i.we;
	assign lwb_rd_o = lcyc & gnt_l & ~lrg_ack & ~lwb_req_i.we;
	assign ewb_wr_o = ecyc & gnt_e & ~ewb_ack_o & ewb_req_i.we;
	assign ewb_rd_o = ecyc & gnt_e & ~ewb_ack_o & ~ewb_req_i.we;

	a_one_grant: assert property (@(posedge lwb_clk_i) disable iff (comb_res)
		!(gnt_l && gnt_e))
		else $error("both buses granted");

endmodule

// ==== src/delqa_pkg.sv ====
// DELQA register block shared definitions
// register offsets for both buses, bus request bundle,
// host register field layouts and Ethernet status layouts
package delqa_pkg;

	localparam int DAT_W = 16;	// bus data width
	localparam int MAC_W = 48;	// station address width

	// host register space, word offsets (base + 2*n)
	// offsets 2..5 are also the BDL words on write
	typedef enum logic [2:0] {
		MAC0 = 3'd0,	// mac byte 0 / internal blk
		MAC1 = 3'd1,
		MAC2 = 3'd2,	// rbdl low on write
		MAC3 = 3'd3,	// rbdl high on write
		MAC4 = 3'd4,	// tbdl low on write
		MAC5 = 3'd5,	// tbdl high on write
		VAR  = 3'd6,	// vector address
		CSR  = 3'd7	// control/status
	} host_reg_e;

	// ethernet bank on the internal bus
	typedef enum logic [3:0] {
		MODE   = 4'd0,	// mode + status
		CNT    = 4'd1,	// tx/rx byte count
		MDVAL  = 4'd2,	// mdio data
		MDCTRL = 4'd3,	// mdio control + status
		MAC_W0 = 4'd8,	// station address words
		MAC_W1 = 4'd9,
		MAC_W2 = 4'd10,
		MAC_W3 = 4'd11	// address checksum
	} eth_reg_e;

	// one request bundle, host side only looks at adr[2:0]
	typedef struct packed {
		logic [3:0]       adr;
		logic [DAT_W-1:0] dat;
		logic [1:0]       sel;	// byte lanes
		logic             we;
		logic             cyc;
		logic             stb;
	} bus_req_t;

	// csr storage, constant bits added by the read port
	typedef struct packed {
		logic ri;	// 15 rx interrupt, w1c from host
		logic ca;	// 13 carrier, read only
		logic se;	// 10 sanity timer enable
		logic el;	// 09 external loopback
		logic il;	// 08 internal loopback, active low
		logic xi;	// 07 tx interrupt, w1c from host
		logic ie;	// 06 interrupt enable
		logic rl;	// 05 rx list invalid
		logic xl;	// 04 tx list invalid
		logic bd;	// 03 boot/diag rom load
		logic ni;	// 02 nxm interrupt
		logic re;	// 00 receiver enable
	} csr_t;

	typedef struct packed {
		logic       ms;	// mode select
		logic       rs;	// request self test
		logic       s3;	// self test status
		logic       s2;
		logic       s1;
		logic [7:0] iv;	// interrupt vector
		logic       id;	// identity test bit
	} var_t;

	// buffer descriptor list address, 22 bits word aligned
	typedef struct packed {
		logic [14:0] lo;	// address bits 15:1
		logic [5:0]  hi;	// address bits 21:16
	} bdl_t;

	typedef struct packed {
		logic       ready;	// mdio idle
		logic [1:0] speed;	// 10=1000 01=100 00=10
		logic       fdx;	// full duplex
		logic       rsvd;
		logic       mdix;	// crossover
		logic       rx_ok;	// receiver ready
		logic       link;
	} mdstat_t;

	typedef struct packed {
		logic       carrier;	// bit 7
		logic       rx_busy;	// bit 6
		logic [5:0] err;	// rx/tx error flags
	} eth_sts_t;

endpackage

// ==== src/delqa_regs_top.sv ====
// DELQA register block top level
// host bus and internal bus access to the host registers,
// internal bus access to the Ethernet control bank, interrupt out
`timescale 1ns/1ps

module delqa_regs_top #(
	parameter logic [delqa_pkg::MAC_W-1:0] MAC_ADDR = 48'h01_00_00_00_00_02
) (
	input  logic                        lwb_clk_i,
	input  logic                        comb_res,
	input  delqa_pkg::bus_req_t         lwb_req_i,	// internal bus, stb = host regs
	input  delqa_pkg::bus_req_t         ewb_req_i,	// external host bus
	input  logic                        eth_stb_i,	// internal bus, ethernet bank
	output logic [delqa_pkg::DAT_W-1:0] lwb_dat_o,
	output logic                        lwb_ack_o,
	output logic [delqa_pkg::DAT_W-1:0] ewb_dat_o,
	output logic                        ewb_ack_o,
	input  logic                        iack_i,
	output logic                        irq_o,
	input  logic                        s3_i,
	input  logic                        s4_i,
	input  delqa_pkg::eth_sts_t         e_stse_i,
	input  logic [10:0]                 e_rxcntb_i,
	input  logic [15:0]                 e_mdval_i,
	input  delqa_pkg::mdstat_t          e_mdstat_i,
	output logic [7:0]                  e_mode_o,
	output logic [10:0]                 e_txcntb_o,
	output logic [15:0]                 e_mdval_o,
	output logic [6:0]                  e_mdctrl_o
);
	import delqa_pkg::*;

	logic             lwb_wr, lwb_rd, ewb_wr, ewb_rd;	// granted access strobes
	logic             eth_ack;
	csr_t             csr;
	var_t             vreg;
	bdl_t             rbdl, tbdl;
	logic             blk;
	logic [DAT_W-1:0] rp_lwb_dat;	// host regs, internal side
	logic [DAT_W-1:0] eth_dat;	// ethernet bank

	assign lwb_dat_o = eth_stb_i ? eth_dat : rp_lwb_dat;

	bus_arbiter bus_arbiter_inst (
		.lwb_clk_i, .comb_res, .lwb_req_i, .ewb_req_i, .eth_stb_i,
		.lwb_ack_o, .ewb_ack_o, .eth_ack_o(eth_ack),
		.lwb_wr_o(lwb_wr), .lwb_rd_o(lwb_rd), .ewb_wr_o(ewb_wr), .ewb_rd_o(ewb_rd)
	);

	qna_reg_file qna_reg_file_inst (
		.lwb_clk_i, .comb_res, .lwb_req_i, .ewb_req_i,
		.lwb_wr_i(lwb_wr), .ewb_wr_i(ewb_wr), .s3_i, .carrier_i(e_stse_i.carrier),
		.csr_o(csr), .var_o(vreg), .rbdl_o(rbdl), .tbdl_o(tbdl), .blk_o(blk)
	);

	qna_read_port #(.MAC_ADDR(MAC_ADDR)) qna_read_port_inst (
		.lwb_clk_i, .lwb_rd_i(lwb_rd), .ewb_rd_i(ewb_rd),
		.lwb_adr_i(host_reg_e'(lwb_req_i.adr[2:0])),
		.ewb_adr_i(host_reg_e'(ewb_req_i.adr[2:0])),
		.csr_i(csr), .var_i(vreg), .rbdl_i(rbdl), .tbdl_i(tbdl), .blk_i(blk), .s4_i,
		.lwb_dat_o(rp_lwb_dat), .ewb_dat_o
	);

	eth_ctrl_regs #(.MAC_ADDR(MAC_ADDR)) eth_ctrl_regs_inst (
		.lwb_clk_i, .comb_res, .lwb_req_i, .eth_stb_i, .eth_ack_i(eth_ack),
		.csr_i(csr), .e_stse_i, .e_rxcntb_i, .e_mdval_i, .e_mdstat_i,
		.eth_dat_o(eth_dat), .e_mode_o, .e_txcntb_o, .e_mdval_o, .e_mdctrl_o
	);

	irq_gen irq_gen_inst (
		.lwb_clk_i, .comb_res,
		.req_i(csr.ri | csr.xi),	// rx or tx request
		.ie_i(csr.ie), .iack_i, .irq_o
	);

endmodule

// ==== src/eth_ctrl_regs.sv ====
// Ethernet control bank on the internal bus
// mode flags, tx byte count, MDIO data and control, station address
// words; rxdon and the MDIO start bit clear from status
`timescale 1ns/1ps

module eth_ctrl_regs #(
	parameter logic [delqa_pkg::MAC_W-1:0] MAC_ADDR = '0
) (
	input  logic                        lwb_clk_i,
	input  logic                        comb_res,
	input  delqa_pkg::bus_req_t         lwb_req_i,
	input  logic                        eth_stb_i,
	input  logic                        eth_ack_i,
	input  delqa_pkg::csr_t             csr_i,
	input  delqa_pkg::eth_sts_t         e_stse_i,
	input  logic [10:0]                 e_rxcntb_i,
	input  logic [15:0]                 e_mdval_i,
	input  delqa_pkg::mdstat_t          e_mdstat_i,
	output logic [delqa_pkg::DAT_W-1:0] eth_dat_o,
	output logic [7:0]                  e_mode_o,
	output logic [10:0]                 e_txcntb_o,
	output logic [15:0]                 e_mdval_o,
	output logic [6:0]                  e_mdctrl_o
);
	import delqa_pkg::*;

	localparam int MD_START = 5;	// mdctrl: 6 wr/rd, 5 start, 4:0 phy reg
	// additive checksum word over the three address words
	localparam logic [15:0] MAC_SUM = MAC_ADDR[15:0] + MAC_ADDR[31:16] + MAC_ADDR[47:32];

	logic             rxdon, txrdy, skipb, stpac;	// firmware mode flags
	logic             extmode, intextmode, intmode, rxmode;
	logic [10:0]      txcntb;
	logic [15:0]      mdval;
	logic [6:0]       mdctrl;
	logic             estb, wr, rd;
	eth_reg_e         adr;
	logic [DAT_W-1:0] dat;

	assign adr  = eth_reg_e'(lwb_req_i.adr);
	assign dat  = lwb_req_i.dat;
	assign estb = lwb_req_i.cyc & eth_stb_i & ~eth_ack_i;
	assign wr   = estb & lwb_req_i.we;
	assign rd   = estb & ~lwb_req_i.we;

	// loopback/receive mode from csr
	assign intmode    = ~csr_i.il & ~csr_i.el & ~csr_i.re;
	assign intextmode = ~csr_i.il & csr_i.el & ~csr_i.re & ~csr_i.bd;
	assign extmode    = csr_i.il & csr_i.el & ~csr_i.re;
	assign rxmode     = csr_i.re;
	assign e_mode_o   = {rxdon, txrdy, skipb, stpac, extmode, intextmode, intmode, rxmode};

	always_ff @(posedge lwb_clk_i) begin
		if (rd) begin
			case (adr)
				MODE:    eth_dat_o <= {1'b0, e_stse_i.rx_busy, e_stse_i.err, e_mode_o};
				CNT:     eth_dat_o <= {5'b0, e_rxcntb_i};
				MDVAL:   eth_dat_o <= e_mdval_i;
				MDCTRL:  eth_dat_o <= {e_mdstat_i, 1'b0, mdctrl};
				MAC_W0:  eth_dat_o <= MAC_ADDR[15:0];
				MAC_W1:  eth_dat_o <= MAC_ADDR[31:16];
				MAC_W2:  eth_dat_o <= MAC_ADDR[47:32];
				MAC_W3:  eth_dat_o <= MAC_SUM;
				default: eth_dat_o <= '0;
			endcase
		end
	end

	// *******************************************************************
	// writes, flags self clear when idle
	always_ff @(posedge lwb_clk_i or posedge comb_res) begin
		if (comb_res) begin
			{rxdon, txrdy, skipb, stpac} <= 4'b0;
			txcntb <= '0;
			mdval  <= '0;
			mdctrl <= '0;
		end else if (wr) begin
			if (lwb_req_i.sel[0]) begin
				case (adr)
					MODE:   {rxdon, txrdy, skipb, stpac} <= dat[7:4];
					CNT:    txcntb[7:0] <= dat[7:0];
					MDVAL:  mdval[7:0]  <= dat[7:0];
					MDCTRL: mdctrl      <= dat[6:0];
					default: ;
				endcase
			end
			if (lwb_req_i.sel[1]) begin
				case (adr)
					CNT:    txcntb[10:8] <= dat[10:8];
					MDVAL:  mdval[15:8]  <= dat[15:8];
					default: ;
				endcase
			end
		end else begin
			if (!e_stse_i.rx_busy)
				rxdon <= 1'b0;	// receiver done with buffer
			if (!e_mdstat_i.ready)
				mdctrl[MD_START] <= 1'b0;	// mdio took the command
		end
	end

	assign e_txcntb_o = txcntb;
	assign e_mdval_o  = mdval;
	assign e_mdctrl_o = mdctrl;

endmodule

// ==== src/irq_gen.sv ====
// Interrupt generator
// rising edge of the request sets irq while enabled, iack clears it
`timescale 1ns/1ps

module irq_gen (
	input  logic lwb_clk_i,
	input  logic comb_res,
	input  logic req_i,	// ri | xi
	input  logic ie_i,
	input  logic iack_i,
	output logic irq_o
);

	logic req_q;	// previous request level

	always_ff @(posedge lwb_clk_i or posedge comb_res) begin
		if (comb_res) begin
			req_q <= 1'b0;
			irq_o <= 1'b0;
		end else begin
			req_q <= req_i;
			if (iack_i)
				irq_o <= 1'b0;	// vector taken
			else if (req_i && !req_q && ie_i)
				irq_o <= 1'b1;
		end
	end

endmodule

// ==== src/qna_read_port.sv ====
// Host register read port
// registered read data for both buses; host side sees MAC bytes
// on the low offsets, internal side sees blk and the BDLs
`timescale 1ns/1ps

module qna_read_port #(
	parameter logic [delqa_pkg::MAC_W-1:0] MAC_ADDR = '0
) (
	input  logic                        lwb_clk_i,
	input  logic                        lwb_rd_i,
	input  logic                        ewb_rd_i,
	input  delqa_pkg::host_reg_e        lwb_adr_i,
	input  delqa_pkg::host_reg_e        ewb_adr_i,
	input  delqa_pkg::csr_t             csr_i,
	input  delqa_pkg::var_t             var_i,
	input  delqa_pkg::bdl_t             rbdl_i,
	input  delqa_pkg::bdl_t             tbdl_i,
	input  logic                        blk_i,
	input  logic                        s4_i,	// option switch, read live
	output logic [delqa_pkg::DAT_W-1:0] lwb_dat_o,
	output logic [delqa_pkg::DAT_W-1:0] ewb_dat_o
);
	import delqa_pkg::*;

	logic [DAT_W-1:0] csr_w, var_w;

	// pe=0, ok=1, bit 11 and sr read zero
	assign csr_w = {csr_i.ri, 1'b0, csr_i.ca, 1'b1, 1'b0, csr_i.se, csr_i.el,
		csr_i.il, csr_i.xi, csr_i.ie, csr_i.rl, csr_i.xl, csr_i.bd,
		csr_i.ni, 1'b0, csr_i.re};
	assign var_w = {var_i.ms, s4_i, var_i.rs, var_i.s3, var_i.s2, var_i.s1,
		var_i.iv, 1'b0, var_i.id};

	always_ff @(posedge lwb_clk_i) begin
		if (ewb_rd_i) begin
			case (ewb_adr_i)
				VAR:     ewb_dat_o <= var_w;
				CSR:     ewb_dat_o <= csr_w;
				default: ewb_dat_o <= {8'hFF, MAC_ADDR[8*ewb_adr_i +: 8]};	// station addr
			endcase
		end
		if (lwb_rd_i) begin
			case (lwb_adr_i)
				MAC0:    lwb_dat_o <= {15'b0, blk_i};
				MAC2:    lwb_dat_o <= {rbdl_i.lo, 1'b0};
				MAC3:    lwb_dat_o <= {10'b0, rbdl_i.hi};
				MAC4:    lwb_dat_o <= {tbdl_i.lo, 1'b0};
				MAC5:    lwb_dat_o <= {10'b0, tbdl_i.hi};
				VAR:     lwb_dat_o <= var_w;
				CSR:     lwb_dat_o <= csr_w;
				default: lwb_dat_o <= '0;	// offset 1 unused
			endcase
		end
	end

endmodule

// ==== src/qna_reg_file.sv ====
// Host register file
// CSR, VAR, RBDL/TBDL and the block bit, byte lane writes from
// the external host bus and the internal processor bus
`timescale 1ns/1ps

module qna_reg_file (
	input  logic                lwb_clk_i,
	input  logic                comb_res,
	input  delqa_pkg::bus_req_t lwb_req_i,
	input  delqa_pkg::bus_req_t ewb_req_i,
	input  logic                lwb_wr_i,
	input  logic                ewb_wr_i,
	input  logic                s3_i,
	input  logic                carrier_i,
	output delqa_pkg::csr_t     csr_o,
	output delqa_pkg::var_t     var_o,
	output delqa_pkg::bdl_t     rbdl_o,
	output delqa_pkg::bdl_t     tbdl_o,
	output logic                blk_o
);
	import delqa_pkg::*;

	csr_t             csr_q;
	var_t             var_q;
	bdl_t             rbdl_q, tbdl_q;
	logic             blk_q;	// host write lockout
	logic             h_wr;	// host write allowed
	host_reg_e        l_adr, e_adr;
	logic [DAT_W-1:0] l_dat, e_dat;

	assign l_adr = host_reg_e'(lwb_req_i.adr[2:0]);
	assign e_adr = host_reg_e'(ewb_req_i.adr[2:0]);
	assign l_dat = lwb_req_i.dat;
	assign e_dat = ewb_req_i.dat;
	assign h_wr  = ewb_wr_i & ~blk_q;

	// *******************************************************************
	// control state, both buses
	always_ff @(posedge lwb_clk_i or posedge comb_res) begin
		if (comb_res) begin
			csr_q <= '{rl: 1'b1, xl: 1'b1, default: 1'b0};	// lists invalid
			var_q <= '{ms: s3_i, rs: 1'b1, s3: 1'b1, s2: 1'b1, s1: 1'b1,
				iv: 8'h00, id: 1'b0};
			blk_q <= 1'b0;
		end else if (h_wr) begin
			if (ewb_req_i.sel[0]) begin	// low lane
				case (e_adr)
					VAR: begin
						var_q.id      <= e_dat[0];
						var_q.iv[5:0] <= e_dat[7:2];
					end
					CSR: begin
						csr_q.ie <= e_dat[6];
						csr_q.bd <= e_dat[3];
						csr_q.re <= e_dat[0];
						if (e_dat[7]) begin	// w1c
							csr_q.xi <= 1'b0;
							csr_q.ni <= 1'b0;
						end
					end
					default: ;
				endcase
			end
			if (ewb_req_i.sel[1]) begin	// high lane
				case (e_adr)
					MAC3: csr_q.rl <= 1'b0;	// rbdl high written, list valid
					MAC5: csr_q.xl <= 1'b0;	// tbdl high written
					VAR: begin
						var_q.iv[7:6] <= e_dat[9:8];
						var_q.rs      <= e_dat[13];
						var_q.ms      <= e_dat[15];
					end
					CSR: begin
						csr_q.il <= e_dat[8];
						csr_q.el <= e_dat[9];
						csr_q.se <= e_dat[10];
						if (e_dat[15])
							csr_q.ri <= 1'b0;
					end
					default: ;
				endcase
			end
		end else if (lwb_wr_i) begin
			if (lwb_req_i.sel[0]) begin
				case (l_adr)
					MAC0: blk_q <= l_dat[0];
					CSR: begin	// status set by firmware
						csr_q.ni <= l_dat[2];
						csr_q.xl <= l_dat[4];
						csr_q.rl <= l_dat[5];
						csr_q.xi <= l_dat[7];
					end
					default: ;
				endcase
			end
			if (lwb_req_i.sel[1]) begin
				case (l_adr)
					VAR: begin	// self test result
						var_q.s1 <= l_dat[10];
						var_q.s2 <= l_dat[11];
						var_q.s3 <= l_dat[12];
						var_q.rs <= l_dat[13];
					end
					CSR: csr_q.ri <= l_dat[15];
					default: ;
				endcase
			end
		end
	end

	// descriptor list addresses, host side only
	always_ff @(posedge lwb_clk_i) begin
		if (h_wr) begin
			case (e_adr)
				MAC2: begin
					if (ewb_req_i.sel[0]) rbdl_q.lo[6:0]  <= e_dat[7:1];
					if (ewb_req_i.sel[1]) rbdl_q.lo[14:7] <= e_dat[15:8];
				end
				MAC3: if (ewb_req_i.sel[0]) rbdl_q.hi <= e_dat[5:0];
				MAC4: begin
					if (ewb_req_i.sel[0]) tbdl_q.lo[6:0]  <= e_dat[7:1];
					if (ewb_req_i.sel[1]) tbdl_q.lo[14:7] <= e_dat[15:8];
				end
				MAC5: if (ewb_req_i.sel[0]) tbdl_q.hi <= e_dat[5:0];
				default: ;
			endcase
		end
	end

	always_comb begin
		csr_o    = csr_q;
		csr_o.ca = csr_q.il & carrier_i;	// carrier only outside int loopback
	end
	assign var_o  = var_q;
	assign rbdl_o = rbdl_q;
	assign tbdl_o = tbdl_q;
	assign blk_o  = blk_q;

	a_one_writer: assert property (@(posedge lwb_clk_i) disable iff (comb_res)
		!(lwb_wr_i && ewb_wr_i))
		else $error("host and internal write in the same cycle");

endmodule

// ==== verification/tb_delqa_regs.sv ====
// DELQA register block testbench
// drives the host and internal buses with LCG data, keeps a model
// of CSR, VAR, BDL and blk, checks reads, Ethernet bank and irq
`timescale 1ns/1ps

module tb_delqa_regs;
	import delqa_pkg::*;

	localparam logic [MAC_W-1:0] TB_MAC = 48'h02_5a_c3_17_e4_96;
	// roughly 300 bus accesses at about 6 cycles each, with margin
	localparam int MAX_CYCLES = 4000;

	logic             clk;
	logic             comb_res;
	bus_req_t         lwb_req, ewb_req;
	logic             eth_stb;
	logic [DAT_W-1:0] lwb_dat, ewb_dat;
	logic             lwb_ack, ewb_ack;
	logic             iack, irq;
	logic             s3, s4;
	eth_sts_t         e_stse;
	logic [10:0]      e_rxcntb, e_txcntb;
	logic [15:0]      e_mdval_in, e_mdval_out;
	mdstat_t          e_mdstat;
	logic [7:0]       e_mode;
	logic [6:0]       e_mdctrl;

	// reference state
	csr_t        m_csr;
	var_t        m_var;
	bdl_t        m_rbdl, m_tbdl;
	logic        m_blk;
	logic [31:0] lcg_state = 32'h4de8_02be;
	int          cycles = 0;

	delqa_regs_top #(.MAC_ADDR(TB_MAC)) delqa_regs_top_inst (
		.lwb_clk_i(clk), .comb_res(comb_res),
		.lwb_req_i(lwb_req), .ewb_req_i(ewb_req), .eth_stb_i(eth_stb),
		.lwb_dat_o(lwb_dat), .lwb_ack_o(lwb_ack), .ewb_dat_o(ewb_dat), .ewb_ack_o(ewb_ack),
		.iack_i(iack), .irq_o(irq), .s3_i(s3), .s4_i(s4),
		.e_stse_i(e_stse), .e_rxcntb_i(e_rxcntb), .e_mdval_i(e_mdval_in),
		.e_mdstat_i(e_mdstat), .e_mode_o(e_mode), .e_txcntb_o(e_txcntb),
		.e_mdval_o(e_mdval_out), .e_mdctrl_o(e_mdctrl)
	);

	always #10 clk = ~clk;	// 20 ns period

	// ********************************************************************
	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: no finish after %0d cycles, a bus ack never came", cycles);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	end

	function automatic logic [15:0] rand16();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];	// upper bits are the better ones
	endfunction

	task automatic check_word(input string name, input logic [DAT_W-1:0] exp,
		input logic [DAT_W-1:0] act);
		if (exp !== act) begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	task automatic check_csr(input string name, input csr_t exp, input csr_t act);
		if (exp !== act) begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("[ERROR] %s: expected %b, actual %b", name, exp, act);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	// csr fields as they sit in the bus word
	function automatic csr_t word_to_csr(input logic [15:0] w);
		csr_t c;
		c = '{ri: w[15], ca: w[13], se: w[10], el: w[9], il: w[8], xi: w[7],
			ie: w[6], rl: w[5], xl: w[4], bd: w[3], ni: w[2], re: w[0]};
		return c;
	endfunction

	function automatic logic [15:0] var_word();
		return {m_var.ms, s4, m_var.rs, m_var.s3, m_var.s2, m_var.s1,
			m_var.iv, 1'b0, m_var.id};
	endfunction

	function automatic csr_t exp_csr();
		csr_t c;
		c = m_csr;
		c.ca = m_csr.il & e_stse.carrier;
		return c;
	endfunction

	// receive or loopback path picked by the CSR, {ext, intext, int, rx}
	function automatic logic [3:0] exp_mode();
		logic [3:0] m;
		m = 4'b0000;
		if (m_csr.re)
			m[0] = 1'b1;	// normal receive
		else begin
			case ({m_csr.il, m_csr.el})
				2'b00: m[1] = 1'b1;	// internal loopback
				2'b01: m[2] = ~m_csr.bd;	// internal extended loopback
				2'b11: m[3] = 1'b1;	// external loopback
				default: ;
			endcase
		end
		return m;
	endfunction

	// ********************************************************************
	// register model
	task automatic model_host_write(input logic [2:0] a, input logic [15:0] d,
		input logic [1:0] s);
		if (!m_blk) begin	// locked out by blk
			case (a)
				3'd2: begin
					if (s[0]) m_rbdl.lo[6:0] = d[7:1];
					if (s[1]) m_rbdl.lo[14:7] = d[15:8];
				end
				3'd3: begin
					if (s[0]) m_rbdl.hi = d[5:0];
					if (s[1]) m_csr.rl = 1'b0;
				end
				3'd4: begin
					if (s[0]) m_tbdl.lo[6:0] = d[7:1];
					if (s[1]) m_tbdl.lo[14:7] = d[15:8];
				end
				3'd5: begin
					if (s[0]) m_tbdl.hi = d[5:0];
					if (s[1]) m_csr.xl = 1'b0;
				end
				3'd6: begin
					if (s[0]) begin
						m_var.id = d[0];
						m_var.iv[5:0] = d[7:2];
					end
					if (s[1]) begin
						m_var.iv[7:6] = d[9:8];
						m_var.rs = d[13];
						m_var.ms = d[15];
					end
				end
				3'd7: begin
					if (s[0]) begin
						m_csr.ie = d[6];
						m_csr.bd = d[3];
						m_csr.re = d[0];
						if (d[7]) begin
							m_csr.xi = 1'b0;	// write one to clear
							m_csr.ni = 1'b0;
						end
					end
					if (s[1]) begin
						m_csr.il = d[8];
						m_csr.el = d[9];
						m_csr.se = d[10];
						if (d[15]) m_csr.ri = 1'b0;
					end
				end
				default: ;
			endcase
		end
	endtask

	task automatic model_int_write(input logic [2:0] a, input logic [15:0] d,
		input logic [1:0] s);
		if (a == 3'd0 && s[0]) m_blk = d[0];
		if (a == 3'd6 && s[1]) begin
			m_var.s1 = d[10];
			m_var.s2 = d[11];
			m_var.s3 = d[12];
			m_var.rs = d[13];
		end
		if (a == 3'd7) begin
			if (s[0]) begin
				m_csr.ni = d[2];
				m_csr.xl = d[4];
				m_csr.rl = d[5];
				m_csr.xi = d[7];
			end
			if (s[1]) m_csr.ri = d[15];
		end
	endtask

	// ********************************************************************
	// bus cycles, present on falling edge, hold until ack
	task automatic host_access(input logic [2:0] a, input logic [15:0] d,
		input logic [1:0] s, input logic we, output logic [15:0] rd);
		@(negedge clk);
		ewb_req = '{adr: {1'b0, a}, dat: d, sel: s, we: we, cyc: 1'b1, stb: 1'b1};
		do @(negedge clk); while (!ewb_ack);
		rd = ewb_dat;	// valid while ack high
		ewb_req = '0;
	endtask

	task automatic int_access(input logic [3:0] a, input logic [15:0] d,
		input logic [1:0] s, input logic we, input logic eth, output logic [15:0] rd);
		@(negedge clk);
		lwb_req = '{adr: a, dat: d, sel: s, we: we, cyc: 1'b1, stb: ~eth};
		eth_stb = eth;
		do @(negedge clk); while (!lwb_ack);
		rd = lwb_dat;
		lwb_req = '0;
		eth_stb = 1'b0;
	endtask

	// read every host offset from both buses and compare
	task automatic verify_all(input string name);
		logic [15:0] rd;
		logic [15:0] exp;
		check_word({name, " eth mode"}, {12'b0, exp_mode()}, {12'b0, e_mode[3:0]});
		for (int a = 0; a < 8; a++) begin
			host_access(a[2:0], 16'h0, 2'b11, 1'b0, rd);
			if (a == 7) begin
				check_csr({name, " host csr"}, exp_csr(), word_to_csr(rd));
				check_word({name, " host csr const"}, 16'h1000, rd & 16'h5802);
			end else if (a == 6)
				check_word({name, " host var"}, var_word(), rd);
			else
				check_word({name, " host mac"}, {8'hFF, TB_MAC[8*a +: 8]}, rd);
			int_access(a[3:0], 16'h0, 2'b11, 1'b0, 1'b0, rd);
			case (a)
				0: exp = {15'b0, m_blk};
				2: exp = {m_rbdl.lo, 1'b0};
				3: exp = {10'b0, m_rbdl.hi};
				4: exp = {m_tbdl.lo, 1'b0};
				5: exp = {10'b0, m_tbdl.hi};
				6: exp = var_word();
				default: exp = 16'h0;
			endcase
			if (a == 7)
				check_csr({name, " int csr"}, exp_csr(), word_to_csr(rd));
			else
				check_word({name, " int reg"}, exp, rd);
		end
	endtask

	task automatic random_host_writes(input string name, input int n);
		logic [15:0] rd;
		logic [15:0] d;
		logic [2:0]  a;
		logic [1:0]  s;
		for (int i = 0; i < n; i++) begin
			a = 3'd2 + 3'(rand16() % 6);	// BDLs, VAR, CSR
			d = rand16();
			s = rand16() % 4;
			host_access(a, d, s, 1'b1, rd);
			model_host_write(a, d, s);
			if (i % 4 == 3) begin	// some firmware traffic too
				a = 3'd6 + 3'(rand16() % 2);
				d = rand16();
				int_access({1'b0, a}, d, 2'b11, 1'b1, 1'b0, rd);
				model_int_write(a, d, 2'b11);
			end
			if (i % 10 == 9)
				verify_all(name);
		end
	endtask

	initial begin
		logic [15:0] rd, dh, dl;
		logic [10:0] m_txcnt;
		logic [15:0] m_mdval, m_sum;
		logic [6:0]  m_mdctrl;
		logic [3:0]  m_flags;
		logic [3:0]  a;
		logic [1:0]  s;

		clk = 1'b0;
		comb_res = 1'b1;
		lwb_req = '0;
		ewb_req = '0;
		eth_stb = 1'b0;
		iack = 1'b0;
		s3 = 1'b0;
		s4 = 1'b1;
		e_stse = '{carrier: 1'b1, rx_busy: 1'b1, err: 6'h15};
		e_rxcntb = 11'h5a3;
		e_mdval_in = 16'hc0de;
		e_mdstat = 8'h81;	// ready, link
		m_csr = '{rl: 1'b1, xl: 1'b1, default: 1'b0};
		m_var = '{ms: s3, rs: 1'b1, s3: 1'b1, s2: 1'b1, s1: 1'b1, iv: 8'h00, id: 1'b0};
		m_rbdl = '0;
		m_tbdl = '0;
		m_blk = 1'b0;
		repeat (10) @(negedge clk);
		comb_res = 1'b0;

		// reset values
		check_bit("reset irq", 1'b0, irq);
		check_bit("reset ewb ack", 1'b0, ewb_ack);
		check_bit("reset lwb ack", 1'b0, lwb_ack);
		host_access(3'd7, 16'h0, 2'b11, 1'b0, rd);
		check_csr("reset host csr", exp_csr(), word_to_csr(rd));
		host_access(3'd6, 16'h0, 2'b11, 1'b0, rd);
		check_word("reset host var", var_word(), rd);
		int_access(4'd7, 16'h0, 2'b11, 1'b0, 1'b0, rd);
		check_csr("reset int csr", exp_csr(), word_to_csr(rd));
		int_access(4'd6, 16'h0, 2'b11, 1'b0, 1'b0, rd);
		check_word("reset int var", var_word(), rd);

		// BDLs have no reset value so load them fully first
		for (int i = 2; i < 6; i++) begin
			dl = rand16();
			host_access(i[2:0], dl, 2'b11, 1'b1, rd);
			model_host_write(i[2:0], dl, 2'b11);
		end
		verify_all("bdl load");
		random_host_writes("random blk0", 30);

		// lock host writes out
		int_access(4'd0, 16'h0001, 2'b01, 1'b1, 1'b0, rd);
		model_int_write(3'd0, 16'h0001, 2'b01);
		random_host_writes("random blk1", 20);
		int_access(4'd0, 16'h0000, 2'b01, 1'b1, 1'b0, rd);
		model_int_write(3'd0, 16'h0000, 2'b01);
		s4 = 1'b0;	// option switch flipped
		e_stse.carrier = 1'b0;	// carrier lost
		verify_all("unblocked");

		// both buses at once with the host first
		for (int i = 0; i < 4; i++) begin
			a = (i % 2) ? 4'd7 : 4'd6;
			dh = rand16();
			dl = rand16();
			fork
				host_access(a[2:0], dh, 2'b11, 1'b1, rd);
				int_access(a, dl, 2'b11, 1'b1, 1'b0, rd);
			join
			model_host_write(a[2:0], dh, 2'b11);
			model_int_write(a[2:0], dl, 2'b11);
			verify_all("contention");
		end

		// ethernet bank
		m_txcnt = '0;
		m_mdval = '0;
		m_mdctrl = '0;
		m_flags = '0;
		for (int i = 0; i < 20; i++) begin
			a = 4'(rand16() % 4);
			dl = rand16();
			s = rand16() % 4;
			int_access(a, dl, s, 1'b1, 1'b1, rd);
			case (a)
				4'd0: if (s[0]) m_flags = dl[7:4];
				4'd1: begin
					if (s[0]) m_txcnt[7:0] = dl[7:0];
					if (s[1]) m_txcnt[10:8] = dl[10:8];
				end
				4'd2: begin
					if (s[0]) m_mdval[7:0] = dl[7:0];
					if (s[1]) m_mdval[15:8] = dl[15:8];
				end
				default: if (s[0]) m_mdctrl = dl[6:0];
			endcase
			check_word("eth txcnt", {5'b0, m_txcnt}, {5'b0, e_txcntb});
			check_word("eth mdval", m_mdval, e_mdval_out);
			check_word("eth mdctrl", {9'b0, m_mdctrl}, {9'b0, e_mdctrl});
			check_word("eth flags", {12'b0, m_flags}, {12'b0, e_mode[7:4]});
		end
		int_access(4'd3, 16'h0, 2'b11, 1'b0, 1'b1, rd);
		check_word("eth mdctrl read", {e_mdstat, 1'b0, m_mdctrl}, rd);
		int_access(4'd1, 16'h0, 2'b11, 1'b0, 1'b1, rd);
		check_word("eth rxcnt read", {5'b0, e_rxcntb}, rd);
		int_access(4'd2, 16'h0, 2'b11, 1'b0, 1'b1, rd);
		check_word("eth mdval read", e_mdval_in, rd);
		int_access(4'd0, 16'h0, 2'b11, 1'b0, 1'b1, rd);
		check_word("eth mode read",
			{1'b0, e_stse.rx_busy, e_stse.err, m_flags, exp_mode()}, rd);
		m_sum = TB_MAC[15:0] + TB_MAC[31:16] + TB_MAC[47:32];
		for (int i = 0; i < 4; i++) begin
			int_access(4'd8 + 4'(i), 16'h0, 2'b11, 1'b0, 1'b1, rd);
			check_word("eth mac word", (i == 3) ? m_sum : TB_MAC[16*i +: 16], rd);
		end
		int_access(4'd0, 16'h0080, 2'b01, 1'b1, 1'b1, rd);	// rxdon
		int_access(4'd3, 16'h0020, 2'b01, 1'b1, 1'b1, rd);	// mdio start
		check_bit("rxdon set", 1'b1, e_mode[7]);
		check_bit("md start set", 1'b1, e_mdctrl[5]);
		@(negedge clk);
		e_stse.rx_busy = 1'b0;
		e_mdstat.ready = 1'b0;
		@(negedge clk);
		check_bit("rxdon clear", 1'b0, e_mode[7]);
		check_bit("md start clear", 1'b0, e_mdctrl[5]);

		// interrupt enabled then disabled
		host_access(3'd7, 16'h80c0, 2'b11, 1'b1, rd);	// ie, clear ri xi ni
		model_host_write(3'd7, 16'h80c0, 2'b11);
		@(negedge clk);
		iack = 1'b1;
		@(negedge clk);
		iack = 1'b0;
		check_bit("irq idle", 1'b0, irq);
		int_access(4'd7, 16'h0080, 2'b01, 1'b1, 1'b0, rd);
		model_int_write(3'd7, 16'h0080, 2'b01);
		@(negedge clk);
		check_bit("irq on xi", 1'b1, irq);
		iack = 1'b1;
		@(negedge clk);
		iack = 1'b0;
		check_bit("irq after iack", 1'b0, irq);
		host_access(3'd7, 16'h8080, 2'b11, 1'b1, rd);	// ie off, clear xi
		model_host_write(3'd7, 16'h8080, 2'b11);
		int_access(4'd7, 16'h0080, 2'b01, 1'b1, 1'b0, rd);
		model_int_write(3'd7, 16'h0080, 2'b01);
		repeat (3) @(negedge clk);
		check_bit("irq masked", 1'b0, irq);
		verify_all("final");

		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== verilog.f ====
src/delqa_pkg.sv
src/bus_arbiter.sv
src/qna_reg_file.sv
src/qna_read_port.sv
src/eth_ctrl_regs.sv
src/irq_gen.sv
src/delqa_regs_top.sv
verification/tb_delqa_regs.sv
